// File: project.f
+incdir+source
source/llc_pkg.sv
source/llc_req_decode.sv
source/llc_set_array.sv
source/lookup_way.sv
source/llc_update.sv
source/llc_lookup_top.sv
verification/llc_lookup_properties.sv
verification/llc_lookup_tb.sv

// File: source/llc_cfg.svh
`ifndef LLC_CFG_SVH
`define LLC_CFG_SVH

// cache geometry
`define LLC_WAYS 4
`define LLC_SETS 4
`define LLC_SET_BITS 2
`define LLC_TAG_BITS 6

// stored line states
`define LLC_STATE_INVALID 2'b00
`define LLC_STATE_VALID 2'b01
`define LLC_STATE_SD 2'b10

`endif

// File: source/llc_lookup_top.sv
`timescale 1ns/1ps
`include "llc_cfg.svh"

module llc_lookup_top (
    input logic clk,
    input logic rst,
    input logic req_valid,
    input llc_pkg::llc_req_t req,
    output logic busy,
    output logic resp_valid,
    output llc_pkg::llc_resp_t resp
);

    llc_pkg::llc_lookup_t lookup;
    llc_pkg::llc_set_t rd_set;
    logic lookup_en;
    logic upd_en;
    llc_pkg::llc_tag_t tags_buf [`LLC_WAYS];
    llc_pkg::llc_state_t states_buf [`LLC_WAYS];
    llc_pkg::llc_way_t evict_way_buf;
    llc_pkg::llc_way_t way;
    logic evict;
    logic wr_en;
    logic ptr_adv;
    llc_pkg::llc_set_t wr_set;
    llc_pkg::llc_way_t wr_way;
    llc_pkg::llc_tag_t wr_tag;
    llc_pkg::llc_state_t wr_state;

    llc_req_decode i_llc_req_decode (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req(req),
        .lookup(lookup), .rd_set(rd_set),
        .lookup_en(lookup_en), .upd_en(upd_en), .busy(busy)
    );

    llc_set_array i_llc_set_array (
        .clk(clk), .rst(rst), .rd_set(rd_set),
        .tags_buf(tags_buf), .states_buf(states_buf), .evict_way_buf(evict_way_buf),
        .wr_en(wr_en), .ptr_adv(ptr_adv), .wr_set(wr_set), .wr_way(wr_way),
        .wr_tag(wr_tag), .wr_state(wr_state)
    );

    // way_next only matters inside the lookup stage
    lookup_way i_lookup_way (
        .clk(clk), .rst(rst), .tag(lookup.tag),
        .tags_buf(tags_buf), .states_buf(states_buf), .evict_way_buf(evict_way_buf),
        .lookup_en(lookup_en), .way(way), .way_next(), .evict(evict)
    );

    llc_update i_llc_update (
        .clk(clk), .rst(rst), .upd_en(upd_en), .lookup(lookup),
        .way(way), .evict(evict), .tags_buf(tags_buf), .states_buf(states_buf),
        .wr_en(wr_en), .ptr_adv(ptr_adv), .wr_set(wr_set), .wr_way(wr_way),
        .wr_tag(wr_tag), .wr_state(wr_state),
        .resp_valid(resp_valid), .resp(resp)
    );

endmodule

// File: source/llc_pkg.sv
`include "llc_cfg.svh"

package llc_pkg;

    typedef logic [`LLC_TAG_BITS-1:0] llc_tag_t;
    typedef logic [`LLC_SET_BITS-1:0] llc_set_t;
    typedef logic [$clog2(`LLC_WAYS)-1:0] llc_way_t;
    typedef logic [1:0] llc_state_t;
    typedef logic [1:0] llc_op_t;
    // line address, tag above set
    typedef logic [`LLC_TAG_BITS+`LLC_SET_BITS-1:0] llc_addr_t;

    localparam llc_op_t LLC_OP_ACCESS = 2'd0;
    localparam llc_op_t LLC_OP_PIN = 2'd1;
    localparam llc_op_t LLC_OP_INVALIDATE = 2'd2;

    typedef struct packed {
        llc_op_t op;
        llc_addr_t addr;
    } llc_req_t;

    typedef struct packed {
        llc_op_t op;
        llc_set_t set;
        llc_tag_t tag;
    } llc_lookup_t;

    typedef struct packed {
        llc_way_t way;
        logic hit;
        logic evict;
        llc_tag_t victim_tag;
        llc_state_t victim_state;
    } llc_resp_t;

    typedef enum logic [1:0] {
        LLC_BUSY_IDLE,
        LLC_BUSY_LOOKUP,
        LLC_BUSY_UPDATE
    } llc_busy_t;

endpackage

// File: source/llc_req_decode.sv
`timescale 1ns/1ps
`include "llc_cfg.svh"

module llc_req_decode (
    input logic clk,
    input logic rst,
    input logic req_valid,
    input llc_pkg::llc_req_t req,
    output llc_pkg::llc_lookup_t lookup,
    output llc_pkg::llc_set_t rd_set,
    output logic lookup_en,
    output logic upd_en,
    output logic busy
);

    llc_pkg::llc_busy_t state;
    llc_pkg::llc_busy_t state_next;
    logic accept;

    // new request taken only when idle
    assign accept = req_valid && (state == llc_pkg::LLC_BUSY_IDLE);

    always_comb begin
        state_next = state;
        case (state)
            llc_pkg::LLC_BUSY_IDLE: begin
                if (accept) begin
                    state_next = llc_pkg::LLC_BUSY_LOOKUP;
                end
            end
            llc_pkg::LLC_BUSY_LOOKUP: begin
                state_next = llc_pkg::LLC_BUSY_UPDATE;
            end
            llc_pkg::LLC_BUSY_UPDATE: begin
                state_next = llc_pkg::LLC_BUSY_IDLE;
            end
            default: begin
                state_next = llc_pkg::LLC_BUSY_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= llc_pkg::LLC_BUSY_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // split line address into set and tag
    always_ff @(posedge clk) begin
        if (accept) begin
            lookup.op <= req.op;
            lookup.set <= req.addr[`LLC_SET_BITS-1:0];
            lookup.tag <= req.addr[`LLC_SET_BITS +: `LLC_TAG_BITS];
        end
    end

    assign rd_set = lookup.set;

    // one strobe per stage
    assign lookup_en = (state == llc_pkg::LLC_BUSY_LOOKUP);
    assign upd_en = (state == llc_pkg::LLC_BUSY_UPDATE);
    assign busy = (state != llc_pkg::LLC_BUSY_IDLE);

endmodule

// File: source/llc_set_array.sv
`timescale 1ns/1ps
`include "llc_cfg.svh"

module llc_set_array (
    input logic clk,
    input logic rst,
    input llc_pkg::llc_set_t rd_set,
    output llc_pkg::llc_tag_t tags_buf [`LLC_WAYS],
    output llc_pkg::llc_state_t states_buf [`LLC_WAYS],
    output llc_pkg::llc_way_t evict_way_buf,
    input logic wr_en,
    input logic ptr_adv,
    input llc_pkg::llc_set_t wr_set,
    input llc_pkg::llc_way_t wr_way,
    input llc_pkg::llc_tag_t wr_tag,
    input llc_pkg::llc_state_t wr_state
);

    llc_pkg::llc_tag_t tags [`LLC_SETS][`LLC_WAYS];
    llc_pkg::llc_state_t states [`LLC_SETS][`LLC_WAYS];
    llc_pkg::llc_way_t evict_ptr [`LLC_SETS];
    llc_pkg::llc_way_t ptr_next;

    // combinational read of the whole set
    always_comb begin
        for (int w = 0; w < `LLC_WAYS; w++) begin
            tags_buf[w] = tags[rd_set][w];
            states_buf[w] = states[rd_set][w];
        end
    end

    assign evict_way_buf = evict_ptr[rd_set];

    // round robin wraps with the way width
    assign ptr_next = wr_way + llc_pkg::llc_way_t'(1);

    // line storage
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < `LLC_SETS; s++) begin
                for (int w = 0; w < `LLC_WAYS; w++) begin
                    tags[s][w] <= '0;
                    states[s][w] <= `LLC_STATE_INVALID;
                end
            end
        end else if (wr_en) begin
            tags[wr_set][wr_way] <= wr_tag;
            states[wr_set][wr_way] <= wr_state;
        end
    end

    // eviction pointers, one per set
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < `LLC_SETS; s++) begin
                evict_ptr[s] <= '0;
            end
        end else if (wr_en && ptr_adv) begin
            evict_ptr[wr_set] <= ptr_next;
        end
    end

endmodule

// File: source/llc_update.sv
`timescale 1ns/1ps
`include "llc_cfg.svh"

module llc_update (
    input logic clk,
    input logic rst,
    input logic upd_en,
    input llc_pkg::llc_lookup_t lookup,
    input llc_pkg::llc_way_t way,
    input logic evict,
    input llc_pkg::llc_tag_t tags_buf [`LLC_WAYS],
    input llc_pkg::llc_state_t states_buf [`LLC_WAYS],
    output logic wr_en,
    output logic ptr_adv,
    output llc_pkg::llc_set_t wr_set,
    output llc_pkg::llc_way_t wr_way,
    output llc_pkg::llc_tag_t wr_tag,
    output llc_pkg::llc_state_t wr_state,
    output logic resp_valid,
    output llc_pkg::llc_resp_t resp
);

    llc_pkg::llc_tag_t cur_tag;
    llc_pkg::llc_state_t cur_state;
    logic hit;
    logic fill_op;
    logic inv_op;
    logic do_evict;

    // chosen line as it stands before the write
    assign cur_tag = tags_buf[way];
    assign cur_state = states_buf[way];
    assign hit = (cur_tag == lookup.tag) && (cur_state != `LLC_STATE_INVALID);

    assign fill_op = (lookup.op == llc_pkg::LLC_OP_ACCESS) ||
                     (lookup.op == llc_pkg::LLC_OP_PIN);
    assign inv_op = (lookup.op == llc_pkg::LLC_OP_INVALIDATE);

    // invalidate never evicts
    assign do_evict = evict && fill_op;

    always_comb begin
        wr_tag = lookup.tag;
        wr_state = cur_state;
        case (lookup.op)
            llc_pkg::LLC_OP_ACCESS: begin
                wr_state = hit ? cur_state : `LLC_STATE_VALID;
            end
            llc_pkg::LLC_OP_PIN: begin
                wr_state = `LLC_STATE_SD;
            end
            llc_pkg::LLC_OP_INVALIDATE: begin
                wr_tag = cur_tag;
                wr_state = `LLC_STATE_INVALID;
            end
            default: begin
                wr_tag = cur_tag;
            end
        endcase
    end

    assign wr_en = upd_en && (fill_op || (inv_op && hit));
    assign ptr_adv = upd_en && do_evict;
    assign wr_set = lookup.set;
    assign wr_way = way;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= upd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (upd_en) begin
            resp.way <= way;
            resp.hit <= hit;
            resp.evict <= do_evict;
            resp.victim_tag <= do_evict ? cur_tag : '0;
            resp.victim_state <= do_evict ? cur_state : `LLC_STATE_INVALID;
        end
    end

endmodule

// File: source/lookup_way.sv
`timescale 1ns/1ps
`include "llc_cfg.svh"

module lookup_way (
    input logic clk,
    input logic rst,
    input llc_pkg::llc_tag_t tag,
    input llc_pkg::llc_tag_t tags_buf [`LLC_WAYS],
    input llc_pkg::llc_state_t states_buf [`LLC_WAYS],
    input llc_pkg::llc_way_t evict_way_buf,
    input logic lookup_en,
    output llc_pkg::llc_way_t way,
    output llc_pkg::llc_way_t way_next,
    output logic evict
);

    // lowest set bit, zero when none
    function automatic llc_pkg::llc_way_t first_set(input logic [`LLC_WAYS-1:0] vec);
        llc_pkg::llc_way_t idx;
        idx = '0;
        for (int j = `LLC_WAYS - 1; j >= 0; j--) begin
            if (vec[j]) begin
                idx = llc_pkg::llc_way_t'(j);
            end
        end
        return idx;
    endfunction

    logic [`LLC_WAYS-1:0] hit_vec;
    logic [`LLC_WAYS-1:0] empty_vec;
    // indexed by offset from the eviction pointer
    logic [`LLC_WAYS-1:0] valid_rot;
    logic [`LLC_WAYS-1:0] not_sd_rot;
    llc_pkg::llc_way_t rot_way;
    llc_pkg::llc_way_t hit_way;
    llc_pkg::llc_way_t empty_way;
    llc_pkg::llc_way_t valid_way;
    llc_pkg::llc_way_t not_sd_way;
    logic evict_next;

    always_comb begin
        rot_way = evict_way_buf;
        for (int i = 0; i < `LLC_WAYS; i++) begin
            rot_way = llc_pkg::llc_way_t'(i) + evict_way_buf;
            hit_vec[i] = (tags_buf[i] == tag) && (states_buf[i] != `LLC_STATE_INVALID);
            empty_vec[i] = (states_buf[i] == `LLC_STATE_INVALID);
            valid_rot[i] = (states_buf[rot_way] == `LLC_STATE_VALID);
            not_sd_rot[i] = (states_buf[rot_way] != `LLC_STATE_SD);
        end
    end

    assign hit_way = first_set(hit_vec);
    assign empty_way = first_set(empty_vec);
    // back from scan offset to absolute way
    assign valid_way = evict_way_buf + first_set(valid_rot);
    assign not_sd_way = evict_way_buf + first_set(not_sd_rot);

    always_comb begin
        if (|hit_vec) begin
            way_next = hit_way;
            evict_next = 1'b0;
        end else if (|empty_vec) begin
            way_next = empty_way;
            evict_next = 1'b0;
        end else if (|valid_rot) begin
            way_next = valid_way;
            evict_next = 1'b1;
        end else if (|not_sd_rot) begin
            way_next = not_sd_way;
            evict_next = 1'b1;
        end else begin
            // everything pinned, take the pointer way
            way_next = evict_way_buf;
            evict_next = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            way <= '0;
            evict <= 1'b0;
        end else if (lookup_en) begin
            way <= way_next;
            evict <= evict_next;
        end
    end

endmodule

// File: verification/llc_lookup_properties.sv
`timescale 1ns/1ps

module llc_lookup_properties (
    input logic clk,
    input logic rst,
    input logic req_valid,
    input logic busy,
    input logic resp_valid,
    input llc_pkg::llc_resp_t resp
);

    int assert_errors = 0;

    // accepted request answers on the third edge, not earlier
    resp_latency: assert property (
        @(posedge clk) disable iff (!rst)
        (req_valid && !busy) |-> ##1 !resp_valid ##1 !resp_valid ##1 resp_valid
    ) else begin
        $error("response did not follow the request by exactly three edges");
        assert_errors++;
    end

    // source holds off while a transaction is in flight
    no_issue_when_busy: assert property (
        @(posedge clk) disable iff (!rst)
        busy |-> !req_valid
    ) else begin
        $error("request issued while busy was high");
        assert_errors++;
    end

    hit_excludes_evict: assert property (
        @(posedge clk) disable iff (!rst)
        resp_valid |-> !(resp.hit && resp.evict)
    ) else begin
        $error("response reports hit and evict together");
        assert_errors++;
    end

endmodule

bind llc_lookup_top llc_lookup_properties i_llc_lookup_properties (
    .clk(clk),
    .rst(rst),
    .req_valid(req_valid),
    .busy(busy),
    .resp_valid(resp_valid),
    .resp(resp)
);

// File: verification/llc_lookup_tb.sv
`timescale 1ns/1ps
`include "llc_cfg.svh"

module llc_lookup_tb;

    localparam int NUM_TESTS = 23;
    localparam int RESET_CYCLES = 16;
    localparam int RESP_WAIT = 8;
    localparam int RESP_LATENCY = 3;

    localparam llc_pkg::llc_op_t op_acc = llc_pkg::LLC_OP_ACCESS;
    localparam llc_pkg::llc_op_t op_pin = llc_pkg::LLC_OP_PIN;
    localparam llc_pkg::llc_op_t op_inv = llc_pkg::LLC_OP_INVALIDATE;
    localparam llc_pkg::llc_state_t st_inv = `LLC_STATE_INVALID;
    localparam llc_pkg::llc_state_t st_val = `LLC_STATE_VALID;
    localparam llc_pkg::llc_state_t st_sd = `LLC_STATE_SD;

    typedef struct packed {
        llc_pkg::llc_op_t op;
        llc_pkg::llc_tag_t tag;
        llc_pkg::llc_set_t set;
        llc_pkg::llc_resp_t exp;
    } vector_t;

    logic clk;
    logic rst;
    logic req_valid;
    llc_pkg::llc_req_t req;
    logic busy;
    logic resp_valid;
    llc_pkg::llc_resp_t resp;

    vector_t vectors [NUM_TESTS];
    string names [NUM_TESTS];
    int n_loaded;
    int pass_count;
    int fail_count;

    llc_lookup_top i_llc_lookup_top (
        .clk(clk),
        .rst(rst),
        .req_valid(req_valid),
        .req(req),
        .busy(busy),
        .resp_valid(resp_valid),
        .resp(resp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic add_vector(input string name, input llc_pkg::llc_op_t op,
                              input llc_pkg::llc_tag_t tag, input llc_pkg::llc_set_t set,
                              input llc_pkg::llc_way_t way, input logic hit,
                              input logic evict, input llc_pkg::llc_tag_t vtag,
                              input llc_pkg::llc_state_t vstate);
        vector_t v;
        v.op = op;
        v.tag = tag;
        v.set = set;
        v.exp.way = way;
        v.exp.hit = hit;
        v.exp.evict = evict;
        v.exp.victim_tag = vtag;
        v.exp.victim_state = vstate;
        vectors[n_loaded] = v;
        names[n_loaded] = name;
        n_loaded++;
    endtask

    // expected values worked out by hand from the way-selection order
    task automatic load_vectors();
        // cold set 1 fills lowest empty way
        add_vector("cold_fill_w0", op_acc, 6'h01, 2'd1, 2'd0, 1'b0, 1'b0, 6'h00, st_inv);
        add_vector("cold_fill_w1", op_acc, 6'h02, 2'd1, 2'd1, 1'b0, 1'b0, 6'h00, st_inv);
        add_vector("cold_fill_w2", op_acc, 6'h03, 2'd1, 2'd2, 1'b0, 1'b0, 6'h00, st_inv);
        add_vector("cold_fill_w3", op_acc, 6'h04, 2'd1, 2'd3, 1'b0, 1'b0, 6'h00, st_inv);
        add_vector("repeat_hit", op_acc, 6'h02, 2'd1, 2'd1, 1'b1, 1'b0, 6'h00, st_inv);
        add_vector("other_set_fill", op_acc, 6'h02, 2'd2, 2'd0, 1'b0, 1'b0, 6'h00, st_inv);
        // full set, pointer starts at 0
        add_vector("evict_ptr0", op_acc, 6'h05, 2'd1, 2'd0, 1'b0, 1'b1, 6'h01, st_val);
        add_vector("evict_ptr1", op_acc, 6'h06, 2'd1, 2'd1, 1'b0, 1'b1, 6'h02, st_val);
        add_vector("pin_hit_w1", op_pin, 6'h06, 2'd1, 2'd1, 1'b1, 1'b0, 6'h00, st_inv);
        add_vector("pin_hit_w2", op_pin, 6'h03, 2'd1, 2'd2, 1'b1, 1'b0, 6'h00, st_inv);
        add_vector("access_hit_sd", op_acc, 6'h06, 2'd1, 2'd1, 1'b1, 1'b0, 6'h00, st_inv);
        // pointer at 2, way 2 pinned
        add_vector("skip_pinned", op_acc, 6'h07, 2'd1, 2'd3, 1'b0, 1'b1, 6'h04, st_val);
        add_vector("inval_hit", op_inv, 6'h05, 2'd1, 2'd0, 1'b1, 1'b0, 6'h00, st_inv);
        add_vector("refill_empty", op_acc, 6'h08, 2'd1, 2'd0, 1'b0, 1'b0, 6'h00, st_inv);
        add_vector("inval_miss", op_inv, 6'h09, 2'd1, 2'd0, 1'b0, 1'b0, 6'h00, st_inv);
        // pointer must still be 0 after the invalidate miss
        add_vector("ptr_unmoved", op_acc, 6'h0a, 2'd1, 2'd0, 1'b0, 1'b1, 6'h08, st_val);
        add_vector("pin_fill_w0", op_pin, 6'h10, 2'd3, 2'd0, 1'b0, 1'b0, 6'h00, st_inv);
        add_vector("pin_fill_w1", op_pin, 6'h11, 2'd3, 2'd1, 1'b0, 1'b0, 6'h00, st_inv);
        add_vector("pin_fill_w2", op_pin, 6'h12, 2'd3, 2'd2, 1'b0, 1'b0, 6'h00, st_inv);
        add_vector("pin_fill_w3", op_pin, 6'h13, 2'd3, 2'd3, 1'b0, 1'b0, 6'h00, st_inv);
        add_vector("all_sd_evict", op_acc, 6'h14, 2'd3, 2'd0, 1'b0, 1'b1, 6'h10, st_sd);
        // scan from 1 wraps round to the only valid line
        add_vector("wrap_scan", op_pin, 6'h15, 2'd3, 2'd0, 1'b0, 1'b1, 6'h14, st_val);
        add_vector("all_sd_ptr1", op_acc, 6'h16, 2'd3, 2'd1, 1'b0, 1'b1, 6'h11, st_sd);
    endtask

    function automatic bit field_ok(input string name, input string field,
                                    input int unsigned expected, input int unsigned actual);
        if (expected != actual) begin
            $display("[ERROR] %s %s expected %0h actual %0h", name, field, expected, actual);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic apply_vector(input int idx);
        vector_t v;
        int cycles;
        bit got;
        bit ok;
        v = vectors[idx];
        cycles = 0;
        got = 1'b0;
        ok = 1'b1;
        @(posedge clk);
        req_valid <= 1'b1;
        req.op <= v.op;
        req.addr <= {v.tag, v.set};
        @(posedge clk);
        req_valid <= 1'b0;
        // response is read mid-cycle, away from the edges
        while (!got && cycles < RESP_WAIT) begin
            @(negedge clk);
            cycles++;
            if (resp_valid) begin
                got = 1'b1;
            end else if (cycles < RESP_LATENCY) begin
                // busy holds for the whole transaction
                ok = field_ok(names[idx], "busy_in_flight", 1, busy) && ok;
            end
        end
        if (!got) begin
            $display("%s: no response arrived within %0d cycles", names[idx], RESP_WAIT);
            ok = 1'b0;
        end else begin
            ok = field_ok(names[idx], "latency", RESP_LATENCY, cycles) && ok;
            ok = field_ok(names[idx], "busy", 0, busy) && ok;
            ok = field_ok(names[idx], "way", v.exp.way, resp.way) && ok;
            ok = field_ok(names[idx], "hit", v.exp.hit, resp.hit) && ok;
            ok = field_ok(names[idx], "evict", v.exp.evict, resp.evict) && ok;
            ok = field_ok(names[idx], "victim_tag", v.exp.victim_tag, resp.victim_tag) && ok;
            ok = field_ok(names[idx], "victim_state", v.exp.victim_state,
                          resp.victim_state) && ok;
        end
        if (ok) begin
            pass_count++;
            $display("%s: passed", names[idx]);
        end else begin
            fail_count++;
            $display("%s: failed", names[idx]);
        end
    endtask

    initial begin
        req_valid = 1'b0;
        req = '0;
        rst = 1'b0;
        n_loaded = 0;
        pass_count = 0;
        fail_count = 0;
        load_vectors();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b1;
        for (int i = 0; i < n_loaded; i++) begin
            apply_vector(i);
        end
        $display("summary: %0d passed, %0d failed, %0d assertion errors", pass_count,
                 fail_count, i_llc_lookup_top.i_llc_lookup_properties.assert_errors);
        if (fail_count == 0 && i_llc_lookup_top.i_llc_lookup_properties.assert_errors == 0)
        begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // each test needs about five cycles, ten leaves margin
    initial begin
        repeat (RESET_CYCLES + NUM_TESTS * 10) @(posedge clk);
        $display("watchdog expired before all tests completed");
        $display("TEST FAIL");
        $finish;
    end

endmodule
